// File: Makefile
# Verilator build and run for the write-command multiplexer

VERILATOR  := verilator
TOP        := rdma_wr_mux_tb
FILE_LIST  := all.f
OBJ_DIR    := obj_dir
COMMON     := --timing --assert --timescale 1ns/1ns
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 $(COMMON)
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
logic/rdma_mux_pkg.sv
logic/sync_queue.sv
logic/wr_cmd_split.sv
logic/wr_data_ctrl.sv
logic/send_packer.sv
logic/rdma_wr_mux.sv
sim/rdma_wr_mux_assertions.sv
sim/rdma_wr_mux_tb.sv

// File: logic/rdma_mux_pkg.sv
// Shared widths, queue depths and FSM encodings of the write-command multiplexer
// Queue pair number union with a flat view and a vfid/pid view
`default_nettype none

package rdma_mux_pkg;

  // --------------------
  // Datapath
  // --------------------
  localparam int DATA_BITS     = 32;
  localparam int KEEP_BITS     = DATA_BITS / 8;
  // log2 of bytes per beat
  localparam int BEAT_LOG_BITS = $clog2(KEEP_BITS);

  // --------------------
  // Request fields
  // --------------------
  localparam int LEN_BITS   = 12;
  localparam int PID_BITS   = 6;
  localparam int DEST_BITS  = 4;
  localparam int QPN_BITS   = DEST_BITS + PID_BITS;
  localparam int VADDR_BITS = 32;

  // Beat counter, wide enough for a full-length transfer
  localparam int CNT_BITS = LEN_BITS - BEAT_LOG_BITS + 1;

  // --------------------
  // Queue words and depths
  // --------------------
  // Sequence entry {host, pid, vfid, len}
  localparam int SEQ_BITS  = 1 + PID_BITS + DEST_BITS + LEN_BITS;
  // Write command {pid, vfid, len, vaddr}
  localparam int REQ_BITS  = PID_BITS + DEST_BITS + LEN_BITS + VADDR_BITS;
  // Write beat {tdata, tkeep, tid, tlast}
  localparam int AXIS_BITS = DATA_BITS + KEEP_BITS + PID_BITS + 1;
  // Send word {qpn, last, msg}
  localparam int RQ_BITS   = QPN_BITS + 1 + DATA_BITS;

  localparam int N_OUTSTANDING = 8;
  localparam int REQ_DEPTH     = 4;
  localparam int DATA_DEPTH    = 16;
  localparam int RQ_DEPTH      = 8;

  // Data controller states
  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_MUX  = 1'b1;

  // Queue pair number, vfid in the upper bits
  typedef union packed {
    logic [QPN_BITS-1:0] flat;
    struct packed {
      logic [DEST_BITS-1:0] vfid;
      logic [PID_BITS-1:0]  pid;
    } split;
  } qpn_u;

endpackage

`default_nettype wire

// File: logic/rdma_wr_mux.sv
// Write-command multiplexer top level
// Command splitter, data controller, send packer and four queues
`timescale 1ns/1ns
`default_nettype none

module rdma_wr_mux
  import rdma_mux_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  // User requests
  input  logic                  s_req_valid,
  output logic                  s_req_ready,
  input  logic                  s_req_host,
  input  logic [PID_BITS-1:0]   s_req_pid,
  input  logic [DEST_BITS-1:0]  s_req_vfid,
  input  logic [LEN_BITS-1:0]   s_req_len,
  input  logic [VADDR_BITS-1:0] s_req_vaddr,
  // RDMA write commands
  output logic                  m_req_wr_valid,
  input  logic                  m_req_wr_ready,
  output logic [PID_BITS-1:0]   m_req_wr_pid,
  output logic [DEST_BITS-1:0]  m_req_wr_vfid,
  output logic [LEN_BITS-1:0]   m_req_wr_len,
  output logic [VADDR_BITS-1:0] m_req_wr_vaddr,
  // Payload input
  input  logic                  s_axis_wr_tvalid,
  output logic                  s_axis_wr_tready,
  input  logic [DATA_BITS-1:0]  s_axis_wr_tdata,
  input  logic [KEEP_BITS-1:0]  s_axis_wr_tkeep,
  input  logic [PID_BITS-1:0]   s_axis_wr_tid,
  input  logic                  s_axis_wr_tlast,
  // RDMA write payload
  output logic                  m_axis_wr_tvalid,
  input  logic                  m_axis_wr_tready,
  output logic [DATA_BITS-1:0]  m_axis_wr_tdata,
  output logic [KEEP_BITS-1:0]  m_axis_wr_tkeep,
  output logic [PID_BITS-1:0]   m_axis_wr_tid,
  output logic                  m_axis_wr_tlast,
  // Send words
  output logic                  m_rq_valid,
  input  logic                  m_rq_ready,
  output qpn_u                  m_rq_qpn,
  output logic                  m_rq_last,
  output logic [DATA_BITS-1:0]  m_rq_msg
);

  // --------------------
  // Internal streams
  // --------------------
  logic seq_in_valid, seq_in_ready, seq_out_valid, seq_out_ready;
  logic [SEQ_BITS-1:0] seq_in_data, seq_out_data;

  logic req_in_valid, req_in_ready;
  logic [REQ_BITS-1:0] req_in_data, req_out_data;

  // Write beats into the data queue
  logic wr_tvalid, wr_tready, wr_tlast;
  logic [DATA_BITS-1:0] wr_tdata;
  logic [KEEP_BITS-1:0] wr_tkeep;
  logic [PID_BITS-1:0]  wr_tid;
  logic [AXIS_BITS-1:0] data_out;

  // Send beats into the packer, packed words into the send queue
  logic snd_valid, snd_ready, snd_last;
  logic [DATA_BITS-1:0] snd_data;
  logic [DEST_BITS-1:0] cur_vfid;
  logic [PID_BITS-1:0]  cur_pid;
  logic rq_valid, rq_ready, rq_last;
  qpn_u rq_qpn;
  logic [DATA_BITS-1:0] rq_msg;
  logic [RQ_BITS-1:0]   rq_out_data;

  assign {m_req_wr_pid, m_req_wr_vfid, m_req_wr_len, m_req_wr_vaddr} = req_out_data;
  assign {m_axis_wr_tdata, m_axis_wr_tkeep, m_axis_wr_tid, m_axis_wr_tlast} = data_out;
  assign {m_rq_qpn, m_rq_last, m_rq_msg} = rq_out_data;

  // --------------------
  // Command path
  // --------------------
  wr_cmd_split u_split (
    .aclk(aclk), .aresetn(aresetn),
    .req_valid(s_req_valid), .req_ready(s_req_ready), .req_host(s_req_host),
    .req_pid(s_req_pid), .req_vfid(s_req_vfid), .req_len(s_req_len),
    .req_vaddr(s_req_vaddr),
    .seq_valid(seq_in_valid), .seq_ready(seq_in_ready), .seq_data(seq_in_data),
    .wr_valid(req_in_valid), .wr_ready(req_in_ready), .wr_data(req_in_data)
  );

  // One entry per accepted command, host or not
  sync_queue #(.WIDTH(SEQ_BITS), .DEPTH(N_OUTSTANDING)) u_seq_q (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(seq_in_valid), .in_ready(seq_in_ready), .in_data(seq_in_data),
    .out_valid(seq_out_valid), .out_ready(seq_out_ready), .out_data(seq_out_data)
  );

  sync_queue #(.WIDTH(REQ_BITS), .DEPTH(REQ_DEPTH)) u_req_q (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(req_in_valid), .in_ready(req_in_ready), .in_data(req_in_data),
    .out_valid(m_req_wr_valid), .out_ready(m_req_wr_ready), .out_data(req_out_data)
  );

  // --------------------
  // Data path
  // --------------------
  wr_data_ctrl u_ctrl (
    .aclk(aclk), .aresetn(aresetn),
    .seq_valid(seq_out_valid), .seq_ready(seq_out_ready), .seq_data(seq_out_data),
    .s_tvalid(s_axis_wr_tvalid), .s_tready(s_axis_wr_tready),
    .s_tdata(s_axis_wr_tdata), .s_tkeep(s_axis_wr_tkeep),
    .s_tid(s_axis_wr_tid), .s_tlast(s_axis_wr_tlast),
    .wr_tvalid(wr_tvalid), .wr_tready(wr_tready), .wr_tdata(wr_tdata),
    .wr_tkeep(wr_tkeep), .wr_tid(wr_tid), .wr_tlast(wr_tlast),
    .snd_valid(snd_valid), .snd_ready(snd_ready), .snd_data(snd_data),
    .snd_last(snd_last), .cur_vfid(cur_vfid), .cur_pid(cur_pid)
  );

  sync_queue #(.WIDTH(AXIS_BITS), .DEPTH(DATA_DEPTH)) u_data_q (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(wr_tvalid), .in_ready(wr_tready),
    .in_data({wr_tdata, wr_tkeep, wr_tid, wr_tlast}),
    .out_valid(m_axis_wr_tvalid), .out_ready(m_axis_wr_tready), .out_data(data_out)
  );

  send_packer u_packer (
    .aclk(aclk), .aresetn(aresetn),
    .beat_valid(snd_valid), .beat_ready(snd_ready), .beat_data(snd_data),
    .beat_last(snd_last), .vfid(cur_vfid), .pid(cur_pid),
    .rq_valid(rq_valid), .rq_ready(rq_ready), .rq_qpn(rq_qpn),
    .rq_last(rq_last), .rq_msg(rq_msg)
  );

  sync_queue #(.WIDTH(RQ_BITS), .DEPTH(RQ_DEPTH)) u_rq_q (
    .aclk(aclk), .aresetn(aresetn),
    .in_valid(rq_valid), .in_ready(rq_ready), .in_data({rq_qpn, rq_last, rq_msg}),
    .out_valid(m_rq_valid), .out_ready(m_rq_ready), .out_data(rq_out_data)
  );

endmodule

`default_nettype wire

// File: logic/send_packer.sv
// Send-queue word packer
// Builds qpn from vfid and pid, one output register with pass-through back-pressure
`timescale 1ns/1ns
`default_nettype none

module send_packer
  import rdma_mux_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  // Send beats from the controller
  input  logic                 beat_valid,
  output logic                 beat_ready,
  input  logic [DATA_BITS-1:0] beat_data,
  input  logic                 beat_last,
  input  logic [DEST_BITS-1:0] vfid,
  input  logic [PID_BITS-1:0]  pid,
  // Send word
  output logic                 rq_valid,
  input  logic                 rq_ready,
  output qpn_u                 rq_qpn,
  output logic                 rq_last,
  output logic [DATA_BITS-1:0] rq_msg
);

  qpn_u qpn_w;
  logic load;

  // vfid on top, pid below
  always_comb begin
    qpn_w.split.vfid = vfid;
    qpn_w.split.pid  = pid;
  end

  // Take a beat when the register is empty or draining
  assign beat_ready = !rq_valid || rq_ready;
  assign load       = beat_valid && beat_ready;

  // --------------------
  // Output register
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rq_valid <= 1'b0;
    end else if (load) begin
      rq_valid <= 1'b1;
    end else if (rq_ready) begin
      rq_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      rq_qpn  <= qpn_w;
      rq_last <= beat_last;
      rq_msg  <= beat_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/sync_queue.sv
// Synchronous valid/ready FIFO
// Circular buffer, simultaneous push and pop allowed
`timescale 1ns/1ns
`default_nettype none

module sync_queue #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  // Write side
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  // Read side
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  // Storage, DEPTH is a power of two so pointers wrap on their own
  logic [WIDTH-1:0] mem [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH):0]   count;

  logic push;
  logic pop;

  // Room and data flags straight from the occupancy count
  assign in_ready  = (count != ($clog2(DEPTH)+1)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // --------------------
  // Storage write
  // --------------------
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop together leave the count as it is
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/wr_cmd_split.sv
// Write command splitter
// Every request goes to the sequence queue, host requests also to the request queue
`timescale 1ns/1ns
`default_nettype none

module wr_cmd_split
  import rdma_mux_pkg::*;
(
  input  logic                  aclk,
  input  logic                  aresetn,
  // User request
  input  logic                  req_valid,
  output logic                  req_ready,
  input  logic                  req_host,
  input  logic [PID_BITS-1:0]   req_pid,
  input  logic [DEST_BITS-1:0]  req_vfid,
  input  logic [LEN_BITS-1:0]   req_len,
  input  logic [VADDR_BITS-1:0] req_vaddr,
  // Sequence queue
  output logic                  seq_valid,
  input  logic                  seq_ready,
  output logic [SEQ_BITS-1:0]   seq_data,
  // Write-command queue
  output logic                  wr_valid,
  input  logic                  wr_ready,
  output logic [REQ_BITS-1:0]   wr_data
);

  // Low through reset, high from the first cycle after it
  logic run;

  // Host requests need room in both queues
  logic path_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  // --------------------
  // Handshake
  // --------------------
  assign path_ready = req_host ? wr_ready : 1'b1;
  assign req_ready  = run && seq_ready && path_ready;

  // Either both queues take the request or neither does
  assign seq_valid = req_valid && req_ready;
  assign wr_valid  = req_valid && req_ready && req_host;

  // --------------------
  // Payload
  // --------------------
  // Sequence entry keeps the host bit for steering
  assign seq_data = {req_host, req_pid, req_vfid, req_len};
  // vaddr only matters on the RDMA write path
  assign wr_data  = {req_pid, req_vfid, req_len, req_vaddr};

endmodule

`default_nettype wire

// File: logic/wr_data_ctrl.sv
// Payload steering FSM
// Pops sequence entries, counts beats, routes each beat to write or send path
`timescale 1ns/1ns
`default_nettype none

module wr_data_ctrl
  import rdma_mux_pkg::*;
(
  input  logic                 aclk,
  input  logic                 aresetn,
  // Sequence queue
  input  logic                 seq_valid,
  output logic                 seq_ready,
  input  logic [SEQ_BITS-1:0]  seq_data,
  // Payload input
  input  logic                 s_tvalid,
  output logic                 s_tready,
  input  logic [DATA_BITS-1:0] s_tdata,
  input  logic [KEEP_BITS-1:0] s_tkeep,
  input  logic [PID_BITS-1:0]  s_tid,
  input  logic                 s_tlast,
  // Write beats
  output logic                 wr_tvalid,
  input  logic                 wr_tready,
  output logic [DATA_BITS-1:0] wr_tdata,
  output logic [KEEP_BITS-1:0] wr_tkeep,
  output logic [PID_BITS-1:0]  wr_tid,
  output logic                 wr_tlast,
  // Send beats
  output logic                 snd_valid,
  input  logic                 snd_ready,
  output logic [DATA_BITS-1:0] snd_data,
  output logic                 snd_last,
  // Held queue pair fields
  output logic [DEST_BITS-1:0] cur_vfid,
  output logic [PID_BITS-1:0]  cur_pid
);

  // Unpacked sequence entry
  logic                 seq_host;
  logic [PID_BITS-1:0]  seq_pid;
  logic [DEST_BITS-1:0] seq_vfid;
  logic [LEN_BITS-1:0]  seq_len;
  logic [CNT_BITS-1:0]  seq_beats;

  // FSM and current transfer
  logic                state;
  logic                host;
  logic [CNT_BITS-1:0] cnt;
  logic [CNT_BITS-1:0] n_beats;

  logic pop;
  logic beat_fire;
  logic last_beat;
  logic tr_done;

  assign {seq_host, seq_pid, seq_vfid, seq_len} = seq_data;

  // Beats = len / 4, rounded up
  assign seq_beats = {1'b0, seq_len[LEN_BITS-1:BEAT_LOG_BITS]}
                   + CNT_BITS'(|seq_len[BEAT_LOG_BITS-1:0]);

  // --------------------
  // Transfer tracking
  // --------------------
  assign beat_fire = s_tvalid && s_tready;
  assign last_beat = (cnt == n_beats - CNT_BITS'(1));
  assign tr_done   = beat_fire && last_beat;

  // Pop when idle, or chain on the final beat
  assign seq_ready = (state == ST_IDLE) || tr_done;
  assign pop       = seq_valid && seq_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else if (pop) begin
      state <= ST_MUX;
      cnt   <= '0;
    end else if (tr_done) begin
      state <= ST_IDLE;
    end else if (beat_fire) begin
      cnt <= cnt + 1'b1;
    end
  end

  // Latched with each popped entry
  always_ff @(posedge aclk) begin
    if (pop) begin
      host     <= seq_host;
      cur_vfid <= seq_vfid;
      cur_pid  <= seq_pid;
      n_beats  <= seq_beats;
    end
  end

  // --------------------
  // Beat steering
  // --------------------
  // Only the latched path sees valid
  assign wr_tvalid = (state == ST_MUX) && host && s_tvalid;
  assign snd_valid = (state == ST_MUX) && !host && s_tvalid;
  assign s_tready  = (state == ST_MUX) && (host ? wr_tready : snd_ready);

  // Write beats pass unchanged
  assign wr_tdata = s_tdata;
  assign wr_tkeep = s_tkeep;
  assign wr_tid   = s_tid;
  assign wr_tlast = s_tlast;

  // Send last comes from the beat count
  assign snd_data = s_tdata;
  assign snd_last = last_beat;

endmodule

`default_nettype wire

// File: sim/rdma_wr_mux_assertions.sv
// Concurrent checks on the data controller
// Bound into every wr_data_ctrl instance
`timescale 1ns/1ns
`default_nettype none

module rdma_wr_mux_assertions
  import rdma_mux_pkg::*;
(
  input logic                aclk,
  input logic                aresetn,
  input logic                state,
  input logic                s_tready,
  input logic                wr_tvalid,
  input logic                snd_valid,
  input logic [CNT_BITS-1:0] cnt,
  input logic [CNT_BITS-1:0] n_beats
);

  // No input beat taken without an open transfer
  idle_no_ready: assert property (@(posedge aclk) disable iff (!aresetn)
    (state == ST_IDLE) |-> !s_tready)
    else $error("data controller input ready high in IDLE");

  // One path at a time
  one_path: assert property (@(posedge aclk) disable iff (!aresetn)
    !(wr_tvalid && snd_valid))
    else $error("write and send path valid in the same cycle");

  // Beat counter stays below the latched beat count
  cnt_in_range: assert property (@(posedge aclk) disable iff (!aresetn)
    (state == ST_MUX) |-> (cnt < n_beats))
    else $error("beat counter ran past the transfer length");

endmodule

bind wr_data_ctrl rdma_wr_mux_assertions u_assertions (
  .aclk(aclk), .aresetn(aresetn), .state(state), .s_tready(s_tready),
  .wr_tvalid(wr_tvalid), .snd_valid(snd_valid), .cnt(cnt), .n_beats(n_beats)
);

`default_nettype wire

// File: sim/rdma_wr_mux_tb.sv
// Testbench for the write-command multiplexer
// LCG-driven requests, payload and output back-pressure
// Reference queues for write commands, write beats and send words
`timescale 1ns/1ns
`default_nettype none

module rdma_wr_mux_tb
  import rdma_mux_pkg::*;
();

  localparam logic [31:0] SEED = 32'h49ca_91d1;
  // Requests over all tests, each one at most 16 beats long
  localparam int TOTAL_REQS  = 120;
  // Send path stall at the start of the fill test
  localparam int HOLD_CYCLES = 200;
  localparam int CYCLE_LIMIT = 40 * TOTAL_REQS * 16 + HOLD_CYCLES;

  logic                  aclk = 1'b0;
  logic                  aresetn;
  logic                  s_req_valid, s_req_ready, s_req_host;
  logic [PID_BITS-1:0]   s_req_pid;
  logic [DEST_BITS-1:0]  s_req_vfid;
  logic [LEN_BITS-1:0]   s_req_len;
  logic [VADDR_BITS-1:0] s_req_vaddr;
  logic                  m_req_wr_valid, m_req_wr_ready;
  logic [PID_BITS-1:0]   m_req_wr_pid;
  logic [DEST_BITS-1:0]  m_req_wr_vfid;
  logic [LEN_BITS-1:0]   m_req_wr_len;
  logic [VADDR_BITS-1:0] m_req_wr_vaddr;
  logic                  s_axis_wr_tvalid, s_axis_wr_tready, s_axis_wr_tlast;
  logic [DATA_BITS-1:0]  s_axis_wr_tdata;
  logic [KEEP_BITS-1:0]  s_axis_wr_tkeep;
  logic [PID_BITS-1:0]   s_axis_wr_tid;
  logic                  m_axis_wr_tvalid, m_axis_wr_tready, m_axis_wr_tlast;
  logic [DATA_BITS-1:0]  m_axis_wr_tdata;
  logic [KEEP_BITS-1:0]  m_axis_wr_tkeep;
  logic [PID_BITS-1:0]   m_axis_wr_tid;
  logic                  m_rq_valid, m_rq_ready, m_rq_last;
  qpn_u                  m_rq_qpn;
  logic [DATA_BITS-1:0]  m_rq_msg;

  // Stimulus control and bookkeeping
  logic [31:0] lcg_state;
  string       test_name;
  int          host_mode;
  int          reqs_left, req_stalls, cycles, hold_end;
  int          errors, test_errors, checks, tests_run;
  logic        req_taken, beat_taken, rand_ready, hold_rq;

  // Expected outputs in acceptance order, pending input beats
  logic [REQ_BITS-1:0]  exp_cmd[$];
  logic [AXIS_BITS-1:0] exp_wr[$];
  logic [RQ_BITS-1:0]   exp_rq[$];
  logic [AXIS_BITS-1:0] pend[$];

  rdma_wr_mux dut (.*);

  initial begin
    forever #4 aclk = ~aclk;
  end

  // Halves swapped, the upper state bits are the better ones
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  task automatic note_failure(string what);
    $display("%s: %s", test_name, what);
    errors++;
    test_errors++;
  endtask

  task automatic compare(string what, logic [63:0] exp, logic [63:0] act);
    checks++;
    if (exp !== act) begin
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Beats per request is len / 4 rounded up
  task automatic add_request();
    logic [31:0]          data;
    logic [31:0]          r;
    logic [AXIS_BITS-1:0] beat;
    logic [QPN_BITS-1:0]  qpn;
    int                   nb;
    int                   b;
    nb  = (int'(s_req_len) + 3) / 4;
    qpn = QPN_BITS'(int'(s_req_vfid) * (1 << PID_BITS) + int'(s_req_pid));
    if (s_req_host) begin
      exp_cmd.push_back({s_req_pid, s_req_vfid, s_req_len, s_req_vaddr});
    end
    for (b = 0; b < nb; b++) begin
      data = next_rand();
      r    = next_rand();
      beat = {data, r[3:0], s_req_pid, (b == nb - 1)};
      pend.push_back(beat);
      if (s_req_host) begin
        exp_wr.push_back(beat);
      end else begin
        exp_rq.push_back({qpn, (b == nb - 1), data});
      end
    end
  endtask

  // --------------------
  // Monitor, sampled on the rising edge
  // --------------------
  always @(posedge aclk) begin
    if (aresetn) begin
      if (s_req_valid && !s_req_ready) begin
        req_stalls++;
      end
      if (s_req_valid && s_req_ready) begin
        add_request();
        req_taken = 1'b1;
      end
      if (s_axis_wr_tvalid && s_axis_wr_tready) begin
        void'(pend.pop_front());
        beat_taken = 1'b1;
      end
      if (m_req_wr_valid && m_req_wr_ready) begin
        if (exp_cmd.size() == 0) begin
          note_failure("write command arrived with none expected");
        end else begin
          compare("m_req_wr", 64'(exp_cmd.pop_front()),
                  64'({m_req_wr_pid, m_req_wr_vfid, m_req_wr_len, m_req_wr_vaddr}));
        end
      end
      if (m_axis_wr_tvalid && m_axis_wr_tready) begin
        if (exp_wr.size() == 0) begin
          note_failure("write beat arrived with none expected");
        end else begin
          compare("m_axis_wr", 64'(exp_wr.pop_front()),
                  64'({m_axis_wr_tdata, m_axis_wr_tkeep, m_axis_wr_tid, m_axis_wr_tlast}));
        end
      end
      if (m_rq_valid && m_rq_ready) begin
        if (exp_rq.size() == 0) begin
          note_failure("send word arrived with none expected");
        end else begin
          compare("m_rq", 64'(exp_rq.pop_front()),
                  64'({m_rq_qpn.flat, m_rq_last, m_rq_msg}));
        end
      end
    end
  end

  // --------------------
  // Driver, falling edge
  // --------------------
  task automatic drive_request();
    logic [31:0] r;
    s_req_vaddr = next_rand();
    r           = next_rand();
    s_req_pid   = r[5:0];
    s_req_vfid  = r[9:6];
    // 1 to 64 bytes
    s_req_len   = LEN_BITS'(r[15:10]) + LEN_BITS'(1);
    r           = next_rand();
    s_req_host  = (host_mode == 2) ? r[0] : (host_mode == 1);
    s_req_valid = 1'b1;
  endtask

  always @(negedge aclk) begin
    logic [31:0] r;
    r = next_rand();
    // A raised valid stays until its handshake
    if (!s_req_valid || req_taken) begin
      req_taken = 1'b0;
      if (reqs_left > 0) begin
        drive_request();
        reqs_left--;
      end else begin
        s_req_valid = 1'b0;
      end
    end
    if (!s_axis_wr_tvalid || beat_taken) begin
      beat_taken = 1'b0;
      if (pend.size() > 0 && r[1:0] != 2'b00) begin
        {s_axis_wr_tdata, s_axis_wr_tkeep, s_axis_wr_tid, s_axis_wr_tlast} = pend[0];
        s_axis_wr_tvalid = 1'b1;
      end else begin
        s_axis_wr_tvalid = 1'b0;
      end
    end
    // Send path held for a fixed stretch so the sequence queue backs up
    if (hold_rq && cycles >= hold_end) begin
      hold_rq = 1'b0;
    end
    m_req_wr_ready   = !rand_ready || r[2];
    m_axis_wr_tready = !rand_ready || r[3];
    m_rq_ready       = !hold_rq && (!rand_ready || r[4]);
  end

  // --------------------
  // Test sequence
  // --------------------
  task automatic finish_test();
    $display("test %s done, %0d errors", test_name, test_errors);
    tests_run++;
    test_errors = 0;
  endtask

  task automatic run_test(string name, int n, int hmode, logic rnd, logic hold);
    @(posedge aclk);
    test_name  = name;
    req_stalls = 0;
    host_mode  = hmode;
    rand_ready = rnd;
    hold_end   = cycles + HOLD_CYCLES;
    hold_rq    = hold;
    reqs_left  = n;
    while (reqs_left > 0 || s_req_valid) begin
      @(posedge aclk);
    end
    while (pend.size() > 0 || exp_cmd.size() > 0 || exp_wr.size() > 0 || exp_rq.size() > 0) begin
      @(posedge aclk);
    end
    // Room for stray words to show up
    repeat (20) @(posedge aclk);
    if (hold && req_stalls == 0) begin
      note_failure("sequence queue never filled, s_req ready stayed high");
    end
    finish_test();
  endtask

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge aclk);
      cycles++;
    end
    $display("timeout: run did not drain within %0d cycles", CYCLE_LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    lcg_state        = SEED;
    aresetn          = 1'b0;
    s_req_valid      = 1'b0;
    s_req_host       = 1'b0;
    s_req_pid        = '0;
    s_req_vfid       = '0;
    s_req_len        = '0;
    s_req_vaddr      = '0;
    m_req_wr_ready   = 1'b1;
    s_axis_wr_tvalid = 1'b0;
    s_axis_wr_tdata  = '0;
    s_axis_wr_tkeep  = '0;
    s_axis_wr_tid    = '0;
    s_axis_wr_tlast  = 1'b0;
    m_axis_wr_tready = 1'b1;
    m_rq_ready       = 1'b1;
    {req_taken, beat_taken, rand_ready, hold_rq} = 4'b0;
    host_mode   = 0;
    reqs_left   = 0;
    req_stalls  = 0;
    hold_end    = 0;
    errors      = 0;
    test_errors = 0;
    checks      = 0;
    tests_run   = 0;

    test_name = "reset_values";
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    if (s_req_ready !== 1'b0) begin
      note_failure("s_req ready high during reset");
    end
    aresetn = 1'b1;
    @(negedge aclk);
    compare("m_req_wr valid", 64'(0), 64'(m_req_wr_valid));
    compare("m_axis_wr tvalid", 64'(0), 64'(m_axis_wr_tvalid));
    compare("m_rq valid", 64'(0), 64'(m_rq_valid));
    finish_test();

    run_test("host_only", 20, 1, 1'b0, 1'b0);
    run_test("send_only", 20, 0, 1'b0, 1'b0);
    run_test("mixed_backpressure", 40, 2, 1'b1, 1'b0);
    run_test("fill_sequence", 40, 0, 1'b1, 1'b1);

    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
